// ==== miriscv_periph_golden.txt ====
// op (0 read, 1 write), address, byte enables, write data, expected read data
// writes carry 00000000 as expected read data
1 00000000 F 11223344 00000000
1 00000004 F A5A5A5A5 00000000
1 000000FC F DEADBEEF 00000000
0 00000000 F 00000000 11223344
1 00000000 2 0000CC00 00000000
1 00000004 9 77000088 00000000
0 00000000 F 00000000 1122CC44
0 00000004 F 00000000 77A5A588
0 000000FC F 00000000 DEADBEEF
1 80000000 F FFFF1234 00000000
0 80000000 F 00000000 00001234
1 80000000 2 0000AB00 00000000
0 80000000 F 00000000 0000AB34
1 80001000 7 000D3A7C 00000000
0 80001000 F 00000000 000D3A7C
1 00000400 F CAFEF00D 00000000
0 00000400 F 00000000 00000000
1 80007000 F 12345678 00000000
0 80007000 F 00000000 00000000
0 80003000 F 00000000 00000000
0 00000000 F 00000000 1122CC44
0 80000000 F 00000000 0000AB34
0 80001000 F 00000000 000D3A7C
1 80001000 4 000F0000 00000000
0 80001000 F 00000000 000F3A7C

// ==== miriscv_periph.f ====
miriscv_pkg.sv
miriscv_bus_if.sv
miriscv_bus_ctrl.sv
miriscv_ram.sv
periph_reg.sv
scan_timer.sv
hex_display.sv
miriscv_periph_top.sv
periph_checker.sv
tb_miriscv_periph.sv

// ==== Bender.yml ====
package:
  name: miriscv_periph

sources:
  - miriscv_pkg.sv
  - miriscv_bus_if.sv
  - miriscv_bus_ctrl.sv
  - miriscv_ram.sv
  - periph_reg.sv
  - scan_timer.sv
  - hex_display.sv
  - miriscv_periph_top.sv
  - target: simulation
    files:
      - periph_checker.sv
      - tb_miriscv_periph.sv

// ==== tb_miriscv_periph.sv ====
`timescale 1ns/1ps

module tb_miriscv_periph;

  localparam int unsigned SCAN_DIV  = 8;
  localparam int unsigned MAX_LINES = 64;

  logic        clk_i;
  logic        rst_n_i;
  logic        data_req_i;
  logic        data_we_i;
  logic [3:0]  data_be_i;
  logic [31:0] data_addr_i;
  logic [31:0] data_wdata_i;
  logic        data_ack_o;
  logic [31:0] data_rdata_o;
  logic [15:0] leds_out_o;
  logic [6:0]  seg_o;
  logic [3:0]  an_o;
  logic [31:0] exp_rdata;
  logic [31:0] golden [5*MAX_LINES]; // five words per access.
  logic [31:0] lfsr;
  logic        loaded;
  int unsigned n_lines;
  int unsigned access_count;
  int unsigned fail_count;
  int unsigned error_count;

  miriscv_periph_top #(
    .SCAN_DIV ( SCAN_DIV )
  ) i_dut (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .data_req_i   ( data_req_i   ),
    .data_we_i    ( data_we_i    ),
    .data_be_i    ( data_be_i    ),
    .data_addr_i  ( data_addr_i  ),
    .data_wdata_i ( data_wdata_i ),
    .data_ack_o   ( data_ack_o   ),
    .data_rdata_o ( data_rdata_o ),
    .leds_out_o   ( leds_out_o   ),
    .seg_o        ( seg_o        ),
    .an_o         ( an_o         )
  );

  periph_checker #(
    .SCAN_DIV ( SCAN_DIV )
  ) i_checker (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .req_i          ( data_req_i   ),
    .we_i           ( data_we_i    ),
    .be_i           ( data_be_i    ),
    .addr_i         ( data_addr_i  ),
    .wdata_i        ( data_wdata_i ),
    .exp_rdata_i    ( exp_rdata    ),
    .ack_i          ( data_ack_o   ),
    .rdata_i        ( data_rdata_o ),
    .leds_i         ( leds_out_o   ),
    .seg_i          ( seg_o        ),
    .an_i           ( an_o         ),
    .access_count_o ( access_count ),
    .fail_count_o   ( fail_count   ),
    .error_count_o  ( error_count  )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic idle_gap();
    logic [1:0] gap;
    gap = '0;
    for (int b = 0; b < 2; b++) begin
      lfsr = lfsr_next(lfsr);
      gap  = {gap[0], lfsr[0]};
    end
    repeat (gap) @(posedge clk_i);
  endtask

  // one full four-phase handshake, entered and left just after a rising edge.
  task automatic run_access(input int unsigned n);
    idle_gap();
    data_req_i   <= 1'b1;
    data_we_i    <= golden[5*n][0];
    data_addr_i  <= golden[5*n+1];
    data_be_i    <= golden[5*n+2][3:0];
    data_wdata_i <= golden[5*n+3];
    exp_rdata    <= golden[5*n+4];
    @(posedge clk_i);
    while (data_ack_o !== 1'b1) @(posedge clk_i);
    data_req_i <= 1'b0;
    @(posedge clk_i);
    while (data_ack_o !== 1'b0) @(posedge clk_i);
  endtask

  initial begin
    rst_n_i      = 1'b0;
    data_req_i   = 1'b0;
    data_we_i    = 1'b0;
    data_be_i    = 4'h0;
    data_addr_i  = '0;
    data_wdata_i = '0;
    exp_rdata    = '0;
    lfsr         = 32'h8309;
    loaded       = 1'b0;
    n_lines      = 0;
    for (int i = 0; i < 5 * MAX_LINES; i++) begin
      golden[i] = 32'hFFFF_FFFF; // an all-ones op word ends the list.
    end
    $readmemh("miriscv_periph_golden.txt", golden);
    while (n_lines < MAX_LINES && golden[5*n_lines] !== 32'hFFFF_FFFF) n_lines++;
    loaded = 1'b1;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    for (int n = 0; n < n_lines; n++) begin
      run_access(n);
    end
    repeat (8 * SCAN_DIV) @(posedge clk_i); // two full scans of the last display value.
    if (n_lines == 0) $display("golden file is missing or holds no accesses");
    if (access_count != n_lines) $display("only %0d of %0d accesses were checked",
                                          access_count, n_lines);
    $display("summary: %0d accesses, %0d failed, %0d errors", access_count, fail_count,
             error_count);
    if (n_lines > 0 && access_count == n_lines && error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    wait (loaded == 1'b1);
    repeat (20 * n_lines * 6 + 8 * SCAN_DIV * 4) @(posedge clk_i);
    $display("timeout: the run did not finish in %0d cycles",
             20 * n_lines * 6 + 8 * SCAN_DIV * 4);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== periph_checker.sv ====
`timescale 1ns/1ps

module periph_checker #(
  parameter int unsigned SCAN_DIV = 8
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  input  logic [31:0] exp_rdata_i,
  input  logic        ack_i,
  input  logic [31:0] rdata_i,
  input  logic [15:0] leds_i,
  input  logic [6:0]  seg_i,
  input  logic [3:0]  an_i,
  output int unsigned access_count_o,
  output int unsigned fail_count_o,
  output int unsigned error_count_o
);

  // active high segments g down to a, digit F in the top slice.
  localparam logic [16*7-1:0] SEG_ON = {7'h71, 7'h79, 7'h5E, 7'h39, 7'h7C, 7'h77, 7'h6F, 7'h7F,
                                        7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F};

  logic [31:0]        ram_model [miriscv_pkg::RAM_SIZE/4];
  miriscv_pkg::leds_t leds_model;
  miriscv_pkg::hex_t  hex_model;
  logic               in_req;
  logic               ack_seen;
  logic               rel_wait;
  logic               reset_seen;
  logic               bad;
  logic               a_we;
  logic [3:0]         a_be;
  logic [31:0]        a_addr;
  logic [6:0]         seg_exp;
  int unsigned        cnt;
  int unsigned        since_lit [4];
  int                 d;

  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] wd,
                                        input logic [3:0] be);
    logic [31:0] r;
    r = old;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) r[8*i +: 8] = wd[8*i +: 8];
    end
    return r;
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] a);
    if (a < miriscv_pkg::RAM_SIZE) return ram_model[a >> 2];
    if (a[31:12] == miriscv_pkg::LEDS_ADDR[31:12]) return 32'(leds_model);
    if (a[31:12] == miriscv_pkg::HEX_ADDR[31:12]) return 32'(hex_model);
    return '0; // unmapped.
  endfunction

  task automatic model_write(input logic [31:0] a, input logic [31:0] wd, input logic [3:0] be);
    logic [31:0] w;
    w = merge(model_read(a), wd, be);
    if (a < miriscv_pkg::RAM_SIZE) begin
      ram_model[a >> 2] = w;
    end else if (a[31:12] == miriscv_pkg::LEDS_ADDR[31:12]) begin
      leds_model = w[$bits(leds_model)-1:0];
    end else if (a[31:12] == miriscv_pkg::HEX_ADDR[31:12]) begin
      hex_model = w[$bits(hex_model)-1:0];
      foreach (since_lit[k]) since_lit[k] = 0; // new digit set, restart the scan window.
    end
  endtask

  task automatic flag_error(input string msg);
    $display("%s", msg);
    error_count_o++;
    bad = 1'b1;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) flag_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_req     = 1'b0;
      ack_seen   = 1'b0;
      rel_wait   = 1'b0;
      reset_seen = 1'b1;
      bad        = 1'b0;
      leds_model = '0;
      hex_model  = '0;
      foreach (since_lit[k]) since_lit[k] = 0;
    end else begin
      if (reset_seen) begin
        reset_seen = 1'b0;
        check_value("data_ack_o", ack_i, 1'b0);
        check_value("an_o", an_i, 4'hF);
        check_value("seg_o", seg_i, 7'h7F);
      end
      if (rel_wait) begin
        rel_wait = 1'b0;
        check_value("data_ack_o", ack_i, 1'b0); // falls at the edge that saw req low.
        access_count_o++;
        if (bad) fail_count_o++;
        $display("access %0d: %s %h be %h %s", access_count_o, a_we ? "write" : "read ",
                 a_addr, a_be, bad ? "FAILED" : "ok");
      end else if (!in_req && req_i) begin
        in_req   = 1'b1;
        ack_seen = 1'b0;
        cnt      = 0;
        bad      = 1'b0;
      end else if (in_req && req_i) begin
        cnt++;
        if (ack_i && !ack_seen) begin
          ack_seen = 1'b1;
          // ack changes at edge 2, so edge 3 is the first to see it.
          if (cnt != 3) flag_error($sformatf("ack rose at edge %0d, expected edge 2", cnt - 1));
          a_we   = we_i;
          a_addr = addr_i;
          a_be   = be_i;
          if (we_i) begin
            model_write(addr_i, wdata_i, be_i);
          end else begin
            check_value("data_rdata_o", rdata_i, exp_rdata_i);
            check_value("data_rdata_o (model)", rdata_i, model_read(addr_i));
          end
        end else if (!ack_seen && cnt == 3) begin
          flag_error("ack did not rise 2 cycles after the request");
        end
      end else if (in_req && !req_i) begin
        in_req   = 1'b0;
        rel_wait = 1'b1;
        check_value("data_ack_o", ack_i, 1'b1);
      end else if (ack_i) begin
        flag_error("ack is high with no request pending");
      end

      // registers may already hold a write the model has not applied yet.
      if (!(in_req && !ack_seen)) begin
        check_value("leds_out_o", leds_i, leds_model);
        if (an_i == 4'hF) begin
          check_value("seg_o", seg_i, 7'h7F);
        end else if ($countones(~an_i) == 1) begin
          for (int k = 0; k < 4; k++) begin
            if (!an_i[k]) d = k;
          end
          if (!hex_model.en[d]) begin
            flag_error($sformatf("disabled digit %0d has its anode driven low", d));
          end else begin
            seg_exp = ~SEG_ON[7*hex_model.digit[d] +: 7];
            check_value("seg_o", seg_i, seg_exp);
          end
        end else begin
          flag_error("more than one anode is low");
        end
      end
      for (int k = 0; k < 4; k++) begin
        since_lit[k] = an_i[k] ? since_lit[k] + 1 : 0;
        if (hex_model.en[k] && since_lit[k] > 4 * SCAN_DIV) begin
          flag_error($sformatf("enabled digit %0d was not shown within one scan", k));
          since_lit[k] = 0;
        end
      end
    end
  end

endmodule

// ==== miriscv_periph_top.sv ====
`timescale 1ns/1ps

module miriscv_periph_top #(
  parameter int unsigned SCAN_DIV = miriscv_pkg::SCAN_DIV
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        data_req_i,
  input  logic        data_we_i,
  input  logic [3:0]  data_be_i,
  input  logic [31:0] data_addr_i,
  input  logic [31:0] data_wdata_i,
  output logic        data_ack_o,
  output logic [31:0] data_rdata_o,
  output logic [15:0] leds_out_o,
  output logic [6:0]  seg_o,
  output logic [3:0]  an_o
);

  miriscv_bus_if mem_bus ();
  miriscv_bus_if leds_bus ();
  miriscv_bus_if hex_bus ();

  miriscv_bus_ctrl i_bus_ctrl (
    .clk_i   ( clk_i        ),
    .rst_n_i ( rst_n_i      ),
    .req_i   ( data_req_i   ),
    .we_i    ( data_we_i    ),
    .be_i    ( data_be_i    ),
    .addr_i  ( data_addr_i  ),
    .wdata_i ( data_wdata_i ),
    .ack_o   ( data_ack_o   ),
    .rdata_o ( data_rdata_o ),
    .mem_o   ( mem_bus      ),
    .leds_o  ( leds_bus     ),
    .hex_o   ( hex_bus      )
  );

  miriscv_ram i_ram (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .bus_i   ( mem_bus )
  );

  periph_reg #(
    .payload_t ( miriscv_pkg::leds_t )
  ) i_leds (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .bus_i   ( leds_bus   ),
    .value_o ( leds_out_o )
  );

  hex_display #(
    .SCAN_DIV ( SCAN_DIV )
  ) i_hex (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .bus_i   ( hex_bus ),
    .seg_o   ( seg_o   ),
    .an_o    ( an_o    )
  );

endmodule

// ==== hex_display.sv ====
`timescale 1ns/1ps

module hex_display #(
  parameter int unsigned SCAN_DIV = 4096
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  miriscv_bus_if.target bus_i,
  output logic [6:0]    seg_o,
  output logic [3:0]    an_o
);

  miriscv_pkg::hex_t hex_q;
  logic [1:0]        digit;
  logic [3:0]        nibble;

  periph_reg #(
    .payload_t ( miriscv_pkg::hex_t )
  ) i_reg (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .bus_i   ( bus_i   ),
    .value_o ( hex_q   )
  );

  scan_timer #(
    .DIV ( SCAN_DIV )
  ) i_scan (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .digit_o ( digit   )
  );

  assign nibble = hex_q.digit[digit];

  always_comb begin
    an_o  = 4'hF;
    seg_o = 7'h7F;                // blank.
    if (hex_q.en[digit]) begin
      an_o[digit] = 1'b0;
      case (nibble)               // active low, g down to a.
        4'h0:    seg_o = 7'h40;
        4'h1:    seg_o = 7'h79;
        4'h2:    seg_o = 7'h24;
        4'h3:    seg_o = 7'h30;
        4'h4:    seg_o = 7'h19;
        4'h5:    seg_o = 7'h12;
        4'h6:    seg_o = 7'h02;
        4'h7:    seg_o = 7'h78;
        4'h8:    seg_o = 7'h00;
        4'h9:    seg_o = 7'h10;
        4'hA:    seg_o = 7'h08;
        4'hB:    seg_o = 7'h03;
        4'hC:    seg_o = 7'h46;
        4'hD:    seg_o = 7'h21;
        4'hE:    seg_o = 7'h06;
        default: seg_o = 7'h0E;
      endcase
    end
  end

endmodule

// ==== scan_timer.sv ====
`timescale 1ns/1ps

module scan_timer #(
  parameter int unsigned DIV = 4096
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  output logic [1:0] digit_o
);

  localparam int unsigned CW = (DIV > 1) ? $clog2(DIV) : 1;

  logic [CW-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q   <= CW'(DIV - 1);
      digit_o <= 2'd0;
    end else if (cnt_q == '0) begin
      cnt_q   <= CW'(DIV - 1);
      digit_o <= digit_o + 2'd1; // wraps 3 to 0.
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

// ==== periph_reg.sv ====
`timescale 1ns/1ps

module periph_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  miriscv_bus_if.target bus_i,
  output payload_t      value_o
);

  localparam int unsigned W = $bits(payload_t);

  logic [W-1:0] value_q;
  logic [31:0]  cur_word;
  logic [31:0]  next_word;

  always_comb begin
    cur_word          = '0;
    cur_word[W-1:0]   = value_q; // zero-extended.
    next_word         = cur_word;
    for (int i = 0; i < 4; i++) begin
      if (bus_i.be[i]) begin
        next_word[8*i +: 8] = bus_i.wdata[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      value_q <= '0;
    end else if (bus_i.stb && bus_i.we) begin
      value_q <= next_word[W-1:0]; // bits above the payload are dropped.
    end
  end

  assign bus_i.rdata = cur_word;
  assign value_o     = payload_t'(value_q);

endmodule

// ==== miriscv_ram.sv ====
`timescale 1ns/1ps

module miriscv_ram (
  input  logic          clk_i,
  input  logic          rst_n_i,
  miriscv_bus_if.target bus_i
);

  localparam int unsigned WORDS = miriscv_pkg::RAM_SIZE / 4;
  localparam int unsigned AW    = $clog2(WORDS);

  logic [31:0]   mem [WORDS];
  logic [31:0]   rdata_q;
  logic [AW-1:0] idx;

  assign idx = bus_i.addr[AW+1:2]; // word index above the byte offset.

  always_ff @(posedge clk_i) begin
    if (bus_i.stb && bus_i.we) begin
      for (int i = 0; i < 4; i++) begin
        if (bus_i.be[i]) begin
          mem[idx][8*i +: 8] <= bus_i.wdata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_i.stb) begin
      rdata_q <= mem[idx]; // valid the cycle after stb.
    end
  end

  assign bus_i.rdata = rdata_q;

  // the decoder must never strobe the RAM outside its range.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_i.stb |-> (bus_i.addr < miriscv_pkg::RAM_SIZE))
    else $error("RAM strobed at out of range address %h", bus_i.addr);

endmodule

// ==== miriscv_bus_ctrl.sv ====
`timescale 1ns/1ps

module miriscv_bus_ctrl (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  output logic        ack_o,
  output logic [31:0] rdata_o,
  miriscv_bus_if.ctrl mem_o,
  miriscv_bus_if.ctrl leds_o,
  miriscv_bus_if.ctrl hex_o
);

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    ACK
  } state_e;

  state_e              state_q;
  state_e              state_d;
  logic                req_q;
  miriscv_pkg::rdsel_e sel_d;
  miriscv_pkg::rdsel_e sel_q;
  logic                strobe;
  logic [31:0]         rdata_mux;

  always_comb begin
    sel_d = miriscv_pkg::RDSEL_NONE;
    if (addr_i < miriscv_pkg::RAM_SIZE) begin
      sel_d = miriscv_pkg::RDSEL_MEM;
    end else if (addr_i >= miriscv_pkg::PERIPH_BASE && addr_i < miriscv_pkg::PERIPH_END) begin
      // one 4 KiB page per register and the rest of the window reads zero.
      if (addr_i[31:12] == miriscv_pkg::LEDS_ADDR[31:12]) begin
        sel_d = miriscv_pkg::RDSEL_LEDS;
      end else if (addr_i[31:12] == miriscv_pkg::HEX_ADDR[31:12]) begin
        sel_d = miriscv_pkg::RDSEL_HEX;
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (req_q) state_d = ACCESS;
      ACCESS:  state_d = ACK;
      ACK:     if (!req_i) state_d = IDLE; // master has released the request.
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      req_q   <= 1'b0;
      sel_q   <= miriscv_pkg::RDSEL_NONE;
    end else begin
      state_q <= state_d;
      req_q   <= req_i;
      if (state_q == IDLE && req_i) begin
        sel_q <= sel_d; // address is held stable while req is high.
      end
    end
  end

  assign strobe = (state_q == IDLE) && req_q; // last idle cycle before ACCESS.
  assign ack_o  = (state_q == ACK);

  assign mem_o.stb  = strobe && (sel_q == miriscv_pkg::RDSEL_MEM);
  assign leds_o.stb = strobe && (sel_q == miriscv_pkg::RDSEL_LEDS);
  assign hex_o.stb  = strobe && (sel_q == miriscv_pkg::RDSEL_HEX);

  assign mem_o.we    = we_i;
  assign mem_o.be    = be_i;
  assign mem_o.addr  = addr_i;
  assign mem_o.wdata = wdata_i;
  assign leds_o.we    = we_i;
  assign leds_o.be    = be_i;
  assign leds_o.addr  = addr_i;
  assign leds_o.wdata = wdata_i;
  assign hex_o.we    = we_i;
  assign hex_o.be    = be_i;
  assign hex_o.addr  = addr_i;
  assign hex_o.wdata = wdata_i;

  always_comb begin
    case (sel_q)
      miriscv_pkg::RDSEL_MEM:  rdata_mux = mem_o.rdata;
      miriscv_pkg::RDSEL_LEDS: rdata_mux = leds_o.rdata;
      miriscv_pkg::RDSEL_HEX:  rdata_mux = hex_o.rdata;
      default:                 rdata_mux = '0; // unmapped reads as zero.
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ACCESS) begin
      rdata_o <= rdata_mux; // held through ACK.
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) $rose(ack_o) |-> req_i)
    else $error("ack raised with no request pending");

  assert property (@(posedge clk_i) disable iff (!rst_n_i) strobe |-> (sel_d == sel_q))
    else $error("strobed target does not match the address on the bus");

endmodule

// ==== miriscv_bus_if.sv ====
`timescale 1ns/1ps

interface miriscv_bus_if;

  logic        stb;   // one cycle per access.
  logic        we;
  logic [3:0]  be;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [31:0] rdata;

  modport ctrl (
    output stb,
    output we,
    output be,
    output addr,
    output wdata,
    input  rdata
  );

  modport target (
    input  stb,
    input  we,
    input  be,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

// ==== miriscv_pkg.sv ====
package miriscv_pkg;

  // memory map.
  localparam int unsigned RAM_SIZE    = 256;           // bytes.
  localparam logic [31:0] PERIPH_BASE = 32'h8000_0000;
  localparam logic [31:0] PERIPH_END  = 32'h8000_6000; // exclusive.
  localparam logic [31:0] LEDS_ADDR   = 32'h8000_0000;
  localparam logic [31:0] HEX_ADDR    = 32'h8000_1000;

  // clock cycles each display digit stays lit.
  localparam int unsigned SCAN_DIV = 4096;

  // which target answers the current access.
  typedef enum logic [1:0] {
    RDSEL_NONE,
    RDSEL_MEM,
    RDSEL_LEDS,
    RDSEL_HEX
  } rdsel_e;

  typedef logic [15:0] leds_t;

  // byte 2 low nibble lands in en, bytes 0 and 1 in the digit values.
  typedef struct packed {
    logic [3:0]      en;    // one bit per digit.
    logic [3:0][3:0] digit; // digit 0 in the low nibble.
  } hex_t;

endpackage
